// File: Makefile
TOP := tb_global_prediction
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --assert -j 0 -f list.f --top $(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "No verdict in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
logic/bp_pkg.sv
logic/resolve_if.sv
logic/global_history.sv
logic/pattern_history_table.sv
logic/branch_target_buffer.sv
logic/branch_correction.sv
logic/fetch_pc.sv
logic/global_prediction_top.sv
verification/global_prediction_assert.sv
verification/tb_global_prediction.sv

// File: logic/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Instruction address
    localparam int ADDR_BITS = 32;
    typedef logic [ADDR_BITS-1:0] addr_t;

    // Global history length and PHT size
    localparam int HIST_BITS = 4;
    localparam int PHT_ENTRIES = 1 << HIST_BITS;

    // 2-bit saturating counter, upper bit is the prediction
    typedef logic [1:0] ctr_t;
    localparam ctr_t CTR_INIT = 2'd1;
    localparam ctr_t CTR_MAX = 2'd3;
    localparam ctr_t CTR_MIN = 2'd0;

    // BTB geometry
    localparam int BTB_IDX_BITS = 4;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_BITS;
    // Index sits just above the word offset
    localparam int BTB_IDX_LSB = 2;
    localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_BITS;
    localparam int BTB_TAG_BITS = ADDR_BITS - BTB_TAG_LSB;
    typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

    // Correction buffer
    localparam int BCB_DEPTH = 4;
    localparam int BCB_PTR_BITS = $clog2(BCB_DEPTH);

    // Fetch sequencing
    localparam addr_t RESET_PC = 32'h0000_0000;
    localparam addr_t INSN_BYTES = 32'd4;

endpackage

`default_nettype wire

// File: logic/branch_correction.sv
`timescale 1ns/100ps
`default_nettype none

module branch_correction (
    input  logic          clk,
    input  logic          rst,
    resolve_if.sink       res,
    input  bp_pkg::addr_t pc,
    input  logic          hit,
    input  logic          taken,
    input  logic          pc_stall,
    output logic          wrong,
    output bp_pkg::addr_t pc_reverse
);

    // Fetch addresses that were predicted taken
    bp_pkg::addr_t                    slot_pc [bp_pkg::BCB_DEPTH];
    logic [bp_pkg::BCB_DEPTH-1:0]     slot_valid;
    logic [bp_pkg::BCB_PTR_BITS-1:0]  wr_ptr;

    // Per-slot compare results
    logic [bp_pkg::BCB_DEPTH-1:0] pc_match;
    logic [bp_pkg::BCB_DEPTH-1:0] ex_match;
    logic                         record;

    always_comb begin
        for (int i = 0; i < bp_pkg::BCB_DEPTH; i++) begin
            pc_match[i] = slot_valid[i] && (slot_pc[i] == pc);
            ex_match[i] = slot_valid[i] && (slot_pc[i] == res.ex_pc);
        end
    end

    // Taken prediction leaving fetch, not already tracked
    assign record = hit && taken && !pc_stall && !(|pc_match);

    // Predicted taken but resolved not taken
    assign wrong = res.ex_branch && !res.pcsrc && (|ex_match);
    // Fall-through of the mispredicted branch
    assign pc_reverse = res.ex_pc + bp_pkg::INSN_BYTES;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
            wr_ptr     <= '0;
        end else begin
            // Any resolution retires its slot
            if (res.ex_branch) begin
                slot_valid <= slot_valid & ~ex_match;
            end
            // Later assignment, so a record beats a clear
            if (record) begin
                slot_valid[wr_ptr] <= 1'b1;
                wr_ptr             <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (record) begin
            slot_pc[wr_ptr] <= pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_target_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer (
    input  logic          clk,
    input  logic          rst,
    resolve_if.sink       res,
    input  bp_pkg::addr_t pc,
    output logic          hit,
    output bp_pkg::addr_t target
);

    // Entry storage
    logic [bp_pkg::BTB_ENTRIES-1:0] valid;
    bp_pkg::btb_tag_t               tags    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t                  targets [bp_pkg::BTB_ENTRIES];

    // Fetch side fields
    logic [bp_pkg::BTB_IDX_BITS-1:0] rd_idx;
    bp_pkg::btb_tag_t                rd_tag;
    // Resolve side fields
    logic [bp_pkg::BTB_IDX_BITS-1:0] wr_idx;
    bp_pkg::btb_tag_t                wr_tag;
    logic                            install;

    assign rd_idx = pc[bp_pkg::BTB_TAG_LSB-1:bp_pkg::BTB_IDX_LSB];
    assign rd_tag = pc[bp_pkg::ADDR_BITS-1:bp_pkg::BTB_TAG_LSB];
    assign wr_idx = res.ex_pc[bp_pkg::BTB_TAG_LSB-1:bp_pkg::BTB_IDX_LSB];
    assign wr_tag = res.ex_pc[bp_pkg::ADDR_BITS-1:bp_pkg::BTB_TAG_LSB];

    // Only taken branches get an entry
    assign install = res.ex_branch && res.pcsrc;

    // Lookup sees contents before this edge's install
    assign hit = valid[rd_idx] && (tags[rd_idx] == rd_tag);
    assign target = targets[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (install) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // Tag and target overwrite whatever aliased there
    always_ff @(posedge clk) begin
        if (install) begin
            tags[wr_idx]    <= wr_tag;
            targets[wr_idx] <= res.pc_branch;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_pc.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_pc (
    input  logic          clk,
    input  logic          rst,
    input  logic          pc_stall,
    input  logic          redirect,
    input  logic          wrong,
    input  logic          predict_taken,
    input  bp_pkg::addr_t pc_branch,
    input  bp_pkg::addr_t pc_reverse,
    input  bp_pkg::addr_t target,
    output bp_pkg::addr_t pc
);

    bp_pkg::addr_t pc_next;

    // Execute corrections outrank the fetch prediction
    always_comb begin
        if (redirect) begin
            pc_next = pc_branch;
        end else if (wrong) begin
            pc_next = pc_reverse;
        end else if (predict_taken) begin
            pc_next = target;
        end else begin
            pc_next = pc + bp_pkg::INSN_BYTES;
        end
    end

    // Hold while fetch is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= bp_pkg::RESET_PC;
        end else if (!pc_stall) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/global_history.sv
`timescale 1ns/100ps
`default_nettype none

module global_history (
    input  logic                         clk,
    input  logic                         rst,
    resolve_if.sink                      res,
    output logic [bp_pkg::HIST_BITS-1:0] history
);

    // Newest outcome enters at bit 0
    // Oldest outcome falls off the top
    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (res.ex_branch) begin
            history <= {history[bp_pkg::HIST_BITS-2:0], res.pcsrc};
        end
    end

endmodule

`default_nettype wire

// File: logic/global_prediction_top.sv
`timescale 1ns/100ps
`default_nettype none

module global_prediction_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          ex_branch,
    input  logic          pcsrc,
    input  logic          pc_stall,
    input  bp_pkg::addr_t ex_pc,
    input  bp_pkg::addr_t pc_branch,
    input  logic          ex_jump,
    input  logic          ex_hit,
    output bp_pkg::addr_t pc,
    output logic          wrong,
    output logic          late_redirect,
    output logic          hit
);

    // Execute resolution bundle
    resolve_if res ();

    assign res.ex_branch = ex_branch;
    assign res.pcsrc     = pcsrc;
    assign res.ex_pc     = ex_pc;
    assign res.pc_branch = pc_branch;

    logic [bp_pkg::HIST_BITS-1:0] history;
    logic                         taken;
    bp_pkg::addr_t                target;
    bp_pkg::addr_t                pc_reverse;
    logic                         redirect;
    logic                         predict_taken;

    // Taken branch that fetch did not see in the BTB
    assign late_redirect = ex_branch && pcsrc && !ex_hit;
    assign redirect      = ex_jump || late_redirect;
    // Follow the BTB target only when the PHT agrees
    assign predict_taken = hit && taken;

    global_history u_global_history (
        .clk     (clk),
        .rst     (rst),
        .res     (res),
        .history (history)
    );

    pattern_history_table u_pattern_history_table (
        .clk     (clk),
        .rst     (rst),
        .res     (res),
        .history (history),
        .taken   (taken)
    );

    branch_target_buffer u_branch_target_buffer (
        .clk    (clk),
        .rst    (rst),
        .res    (res),
        .pc     (pc),
        .hit    (hit),
        .target (target)
    );

    branch_correction u_branch_correction (
        .clk        (clk),
        .rst        (rst),
        .res        (res),
        .pc         (pc),
        .hit        (hit),
        .taken      (taken),
        .pc_stall   (pc_stall),
        .wrong      (wrong),
        .pc_reverse (pc_reverse)
    );

    fetch_pc u_fetch_pc (
        .clk           (clk),
        .rst           (rst),
        .pc_stall      (pc_stall),
        .redirect      (redirect),
        .wrong         (wrong),
        .predict_taken (predict_taken),
        .pc_branch     (pc_branch),
        .pc_reverse    (pc_reverse),
        .target        (target),
        .pc            (pc)
    );

endmodule

`default_nettype wire

// File: logic/pattern_history_table.sv
`timescale 1ns/100ps
`default_nettype none

module pattern_history_table (
    input  logic                         clk,
    input  logic                         rst,
    resolve_if.sink                      res,
    input  logic [bp_pkg::HIST_BITS-1:0] history,
    output logic                         taken
);

    // One counter per history pattern
    bp_pkg::ctr_t ctr [bp_pkg::PHT_ENTRIES];
    bp_pkg::ctr_t cur;

    // Counter under the current history
    // Same entry serves lookup and update
    assign cur = ctr[history];
    assign taken = cur[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < bp_pkg::PHT_ENTRIES; i++) begin
                ctr[i] <= bp_pkg::CTR_INIT;
            end
        end else if (res.ex_branch) begin
            // History is still pre-shift at this edge
            if (res.pcsrc) begin
                if (cur != bp_pkg::CTR_MAX) begin
                    ctr[history] <= cur + 2'd1;
                end
            end else begin
                if (cur != bp_pkg::CTR_MIN) begin
                    ctr[history] <= cur - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/resolve_if.sv
`timescale 1ns/100ps
`default_nettype none

interface resolve_if;

    // Resolution strobe from execute, one cycle wide
    logic ex_branch;
    // Actual outcome, only meaningful with the strobe
    logic pcsrc;
    // Address of the resolved branch
    bp_pkg::addr_t ex_pc;
    // Resolved target
    bp_pkg::addr_t pc_branch;

    // Read side for the predictor tables
    modport sink (
        input ex_branch,
        input pcsrc,
        input ex_pc,
        input pc_branch
    );

endinterface

`default_nettype wire

// File: verification/global_prediction_assert.sv
`timescale 1ns/100ps
`default_nettype none

module global_prediction_assert (
    input logic          clk,
    input logic          rst,
    input logic          pc_stall,
    input logic          ex_jump,
    input logic          wrong,
    input bp_pkg::addr_t ex_pc,
    input bp_pkg::addr_t pc
);

    // Stalled fetch keeps its address
    assert property (@(posedge clk) disable iff (rst) pc_stall |=> $stable(pc))
        else $error("pc changed across a stall");

    // Wrong-taken correction sends fetch to the fall-through
    assert property (@(posedge clk) disable iff (rst)
        (wrong && !ex_jump && !pc_stall) |=> (pc == $past(ex_pc) + bp_pkg::INSN_BYTES))
        else $error("pc did not take the fall-through after wrong");

    // Fetch addresses are whole words
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

bind global_prediction_top global_prediction_assert u_global_prediction_assert (
    .clk      (clk),
    .rst      (rst),
    .pc_stall (pc_stall),
    .ex_jump  (ex_jump),
    .wrong    (wrong),
    .ex_pc    (ex_pc),
    .pc       (pc)
);

`default_nettype wire

// File: verification/tb_global_prediction.sv
`timescale 1ns/100ps
`default_nettype none

module tb_global_prediction;

    localparam int NUM_CYCLES = 2000;
    localparam int CLK_PERIOD = 10;
    localparam int POOL_SIZE = 24;
    // Full run length plus margin
    localparam int WATCHDOG_NS = NUM_CYCLES * CLK_PERIOD + 200;

    logic          clk = 1'b0;
    logic          rst;
    logic          ex_branch;
    logic          pcsrc;
    logic          pc_stall;
    bp_pkg::addr_t ex_pc;
    bp_pkg::addr_t pc_branch;
    logic          ex_jump;
    logic          ex_hit;
    bp_pkg::addr_t pc;
    logic          wrong;
    logic          late_redirect;
    logic          hit;

    // Branch addresses used by execute
    bp_pkg::addr_t pool [POOL_SIZE];

    // Reference model state
    logic [bp_pkg::HIST_BITS-1:0] m_hist;
    bp_pkg::ctr_t                 m_pht        [16];
    logic                         m_btb_valid  [16];
    bp_pkg::btb_tag_t             m_btb_tag    [16];
    bp_pkg::addr_t                m_btb_target [16];
    bp_pkg::addr_t                m_bcb_pc     [4];
    logic                         m_bcb_valid  [4];
    int                           m_bcb_ptr;
    bp_pkg::addr_t                m_pc;

    always #(CLK_PERIOD / 2) clk = ~clk;

    global_prediction_top u_global_prediction_top (
        .clk           (clk),
        .rst           (rst),
        .ex_branch     (ex_branch),
        .pcsrc         (pcsrc),
        .pc_stall      (pc_stall),
        .ex_pc         (ex_pc),
        .pc_branch     (pc_branch),
        .ex_jump       (ex_jump),
        .ex_hit        (ex_hit),
        .pc            (pc),
        .wrong         (wrong),
        .late_redirect (late_redirect),
        .hit           (hit)
    );

    task automatic check_addr(input bp_pkg::addr_t got, input bp_pkg::addr_t exp,
                              input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic model_reset;
        m_hist = '0;
        for (int i = 0; i < 16; i++) begin
            m_pht[i] = 2'd1;
            m_btb_valid[i] = 1'b0;
            m_btb_tag[i] = '0;
            m_btb_target[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            m_bcb_valid[i] = 1'b0;
            m_bcb_pc[i] = '0;
        end
        m_bcb_ptr = 0;
        m_pc = 32'h0000_0000;
    endtask

    task automatic drive_random;
        int sel;
        sel = $urandom % POOL_SIZE;
        ex_pc = pool[sel];
        // Targets stay low so fetch keeps running into pool addresses
        pc_branch = bp_pkg::addr_t'($urandom % 64) << 2;
        ex_branch = ($urandom % 100) < 40;
        pcsrc = ($urandom % 100) < 50;
        ex_jump = ($urandom % 100) < 5;
        pc_stall = ($urandom % 100) < 10;
        ex_hit = 1'($urandom % 2);
    endtask

    // Predict this cycle's outputs, compare, then apply the edge
    task automatic check_and_advance;
        logic [3:0]    p_idx;
        logic [3:0]    e_idx;
        logic          exp_hit;
        logic          exp_taken;
        logic          exp_wrong;
        logic          exp_late;
        logic          in_buf;
        logic          ex_in_buf;
        logic          record;
        logic          ex_match [4];
        bp_pkg::ctr_t  cur;
        bp_pkg::addr_t next_pc;

        // BTB index is pc[5:2], tag is pc[31:6]
        p_idx = m_pc[5:2];
        exp_hit = m_btb_valid[p_idx] && (m_btb_tag[p_idx] == m_pc[31:6]);
        exp_taken = m_pht[m_hist][1];
        in_buf = 1'b0;
        ex_in_buf = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (m_bcb_valid[i] && m_bcb_pc[i] == m_pc) in_buf = 1'b1;
            ex_match[i] = m_bcb_valid[i] && (m_bcb_pc[i] == ex_pc);
            if (ex_match[i]) ex_in_buf = 1'b1;
        end
        exp_wrong = ex_branch && !pcsrc && ex_in_buf;
        exp_late = ex_branch && pcsrc && !ex_hit;
        record = exp_hit && exp_taken && !pc_stall && !in_buf;

        check_addr(pc, m_pc, "pc");
        check_flag(hit, exp_hit, "hit");
        check_flag(wrong, exp_wrong, "wrong");
        check_flag(late_redirect, exp_late, "late_redirect");

        // Redirect, then wrong-taken fall-through, then BTB target
        if (ex_jump || exp_late) next_pc = pc_branch;
        else if (exp_wrong) next_pc = ex_pc + 32'd4;
        else if (exp_hit && exp_taken) next_pc = m_btb_target[p_idx];
        else next_pc = m_pc + 32'd4;

        if (ex_branch) begin
            // Counter under pre-shift history
            cur = m_pht[m_hist];
            if (pcsrc && cur != 2'd3) m_pht[m_hist] = cur + 2'd1;
            else if (!pcsrc && cur != 2'd0) m_pht[m_hist] = cur - 2'd1;
            m_hist = {m_hist[2:0], pcsrc};
            if (pcsrc) begin
                e_idx = ex_pc[5:2];
                m_btb_valid[e_idx] = 1'b1;
                m_btb_tag[e_idx] = ex_pc[31:6];
                m_btb_target[e_idx] = pc_branch;
            end
            for (int i = 0; i < 4; i++) begin
                if (ex_match[i]) m_bcb_valid[i] = 1'b0;
            end
        end
        // Record after clear, same slot keeps the new entry
        if (record) begin
            m_bcb_valid[m_bcb_ptr] = 1'b1;
            m_bcb_pc[m_bcb_ptr] = m_pc;
            m_bcb_ptr = (m_bcb_ptr + 1) % 4;
        end
        if (!pc_stall) m_pc = next_pc;
    endtask

    initial begin
        void'($urandom(73702));
        rst = 1'b1;
        ex_branch = 1'b0;
        pcsrc = 1'b0;
        pc_stall = 1'b0;
        ex_pc = '0;
        pc_branch = '0;
        ex_jump = 1'b0;
        ex_hit = 1'b0;
        // Three 64-byte groups, each hitting the same eight BTB indices
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = bp_pkg::addr_t'((i / 8) * 64 + (i % 8) * 8);
        end
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            drive_random();
            #1;
            check_and_advance();
            @(posedge clk);
            #1;
        end
        $display("*** PASSED ***");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
